// File: design/ec_conv_pkg.sv
`default_nettype none

package ec_conv_pkg;

  // ########################################
  // default sizes
  // ########################################

  localparam int DEF_BITS       = 32; // residue width
  localparam int DEF_FIFO_DEPTH = 2;  // X values held while inverse runs

  // ########################################
  // fsm encodings
  // ########################################

  // binary gcd inverter
  typedef enum logic [2:0] {
    INV_IDLE,     // waiting for Z
    INV_U_HALVE,  // strip factors of two from u
    INV_V_HALVE,  // strip factors of two from v
    INV_SUBTRACT, // larger of u, v minus the smaller
    INV_DONE      // result presented downstream
  } inv_state_t;

  // shift-and-add multiplier
  typedef enum logic [1:0] {
    MUL_IDLE, // ready for operands
    MUL_RUN,  // one bit of op_b per cycle
    MUL_DONE  // product held for consumer
  } mul_state_t;

endpackage

`default_nettype wire

// File: design/mul_op_if.sv
`timescale 1ns/1ps
`default_nettype none

// one multiplication request, inverse times X
interface mul_op_if #(
  parameter int BITS = ec_conv_pkg::DEF_BITS
);

  logic [BITS-1:0] op_a;   // inverse of Z
  logic [BITS-1:0] op_b;   // matching X
  logic            op_val; // both operands present
  logic            op_rdy; // multiplier idle

  // join logic side
  modport source (output op_a, output op_b, output op_val, input op_rdy);

  // multiplier side
  modport sink (input op_a, input op_b, input op_val, output op_rdy);

endinterface

`default_nettype wire

// File: design/bin_inv.sv
`timescale 1ns/1ps
`default_nettype none

module bin_inv #(
  parameter int BITS = ec_conv_pkg::DEF_BITS
) (
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire [BITS-1:0]   i_dat,  // Z, nonzero and below p
  input  wire              i_val,
  input  wire [BITS-1:0]   i_p,    // odd prime modulus
  output logic             o_rdy,
  output logic [BITS-1:0]  o_dat,  // Z^-1 mod p
  output logic             o_val,
  input  wire              i_rdy
);

  import ec_conv_pkg::*;

  inv_state_t      state;
  logic [BITS-1:0] u, v;         // gcd operands, start at Z and p
  logic [BITS:0]   x1, x2;       // coefficients, x1*Z == u and x2*Z == v
  logic [BITS-1:0] p_l;          // latched modulus
  logic [BITS:0]   p_ext;
  logic [BITS-1:0] u_sub_v, v_sub_u;
  logic [BITS:0]   x1_half, x2_half;
  logic [BITS:0]   x1_sub_x2, x2_sub_x1;
  logic            sub_seen;     // a SUBTRACT step since the last load

  // ########################################
  // datapath helpers
  // ########################################

  assign p_ext = {1'b0, p_l};

  always_comb begin
    u_sub_v = u - v; // only used when u >= v
    v_sub_u = v - u;
    // halving mod p, add p first when odd so the shift stays exact
    x1_half = x1[0] ? ((x1 + p_ext) >> 1) : (x1 >> 1);
    x2_half = x2[0] ? ((x2 + p_ext) >> 1) : (x2 >> 1);
    // difference kept in [0, p)
    x1_sub_x2 = x1 + ((x1 >= x2) ? '0 : p_ext) - x2;
    x2_sub_x1 = x2 + ((x2 >= x1) ? '0 : p_ext) - x1;
  end

  // ########################################
  // control fsm
  // ########################################

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= INV_IDLE;
      o_rdy    <= 1'b0;
      o_val    <= 1'b0;
      sub_seen <= 1'b0;
    end else begin
      o_rdy <= 1'b0; // high only in idle
      case (state)
        INV_IDLE: begin
          o_rdy <= 1'b1;
          if (o_rdy && i_val) begin
            o_rdy    <= 1'b0;
            u        <= i_dat;
            v        <= i_p;
            p_l      <= i_p;
            x1       <= (BITS+1)'(1);
            x2       <= '0;
            sub_seen <= 1'b0;
            state    <= INV_U_HALVE;
          end
        end
        INV_U_HALVE: begin
          if (u[0]) begin
            state <= INV_V_HALVE;
          end else begin
            u  <= u >> 1;
            x1 <= x1_half;
            if (u[1]) state <= INV_V_HALVE; // next u is odd
          end
        end
        INV_V_HALVE: begin
          if (v[0]) begin
            state <= INV_SUBTRACT;
          end else begin
            v  <= v >> 1;
            x2 <= x2_half;
            if (v[1]) state <= INV_SUBTRACT;
          end
        end
        INV_SUBTRACT: begin
          // u and v are both odd here, so a difference is never one
          sub_seen <= 1'b1;
          state    <= INV_U_HALVE;
          if (u >= v) begin
            u  <= u_sub_v;
            x1 <= x1_sub_x2;
            if (v == BITS'(1)) state <= INV_DONE;
          end else begin
            v  <= v_sub_u;
            x2 <= x2_sub_x1;
            if (u == BITS'(1)) state <= INV_DONE;
          end
        end
        INV_DONE: begin
          if (!o_val) begin
            o_val <= 1'b1;
            o_dat <= (u == BITS'(1)) ? x1[BITS-1:0] : x2[BITS-1:0];
          end else if (i_rdy) begin
            o_val <= 1'b0;
            o_rdy <= 1'b1; // ready again right after the transfer
            state <= INV_IDLE;
          end
        end
        default: state <= INV_IDLE;
      endcase
    end
  end

  // ########################################
  // checks
  // ########################################

  // a result always comes out of at least one subtraction step
  a_done_after_sub: assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(o_val) |-> sub_seen);

  // result held under back-pressure
  a_hold_dat: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_val && !i_rdy) |=> (o_val && $stable(o_dat)));

endmodule

`default_nettype wire

// File: design/mod_mult.sv
`timescale 1ns/1ps
`default_nettype none

module mod_mult #(
  parameter int BITS = ec_conv_pkg::DEF_BITS
) (
  input  wire              i_clk,
  input  wire              i_rst,
  mul_op_if.sink           i_op,
  input  wire [BITS-1:0]   i_p,    // modulus, stable while busy
  output logic [BITS-1:0]  o_dat,  // op_a * op_b mod p
  output logic             o_val,
  input  wire              i_rdy
);

  import ec_conv_pkg::*;

  localparam int CNT_W = (BITS > 1) ? $clog2(BITS) : 1;

  mul_state_t       state;
  logic [BITS-1:0]  a_l;   // multiplicand
  logic [BITS-1:0]  b_sh;  // multiplier, msb consumed first
  logic [CNT_W-1:0] cnt;   // bits left minus one
  logic [BITS-1:0]  acc;   // running product, always below p
  logic [BITS+1:0]  p_ext;
  logic [BITS+1:0]  acc_sum, acc_red1, acc_red2;

  // ########################################
  // one interleaved step
  // ########################################

  assign p_ext = {2'b00, i_p};

  always_comb begin
    // 2*acc + a stays below 3p, so two subtractions are enough
    acc_sum  = {1'b0, acc, 1'b0} + (b_sh[BITS-1] ? {2'b00, a_l} : '0);
    acc_red1 = (acc_sum >= p_ext) ? (acc_sum - p_ext) : acc_sum;
    acc_red2 = (acc_red1 >= p_ext) ? (acc_red1 - p_ext) : acc_red1;
  end

  assign i_op.op_rdy = (state == MUL_IDLE); // no overlap of requests
  assign o_dat       = acc;                 // frozen once done

  // ########################################
  // control
  // ########################################

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= MUL_IDLE;
      o_val <= 1'b0;
    end else begin
      case (state)
        MUL_IDLE: begin
          if (i_op.op_val) begin
            a_l   <= i_op.op_a;
            b_sh  <= i_op.op_b;
            acc   <= '0;
            cnt   <= CNT_W'(BITS - 1);
            state <= MUL_RUN;
          end
        end
        MUL_RUN: begin
          acc  <= acc_red2[BITS-1:0];
          b_sh <= b_sh << 1;
          cnt  <= cnt - 1'b1;
          if (cnt == '0) begin // last bit, result valid next cycle
            o_val <= 1'b1;
            state <= MUL_DONE;
          end
        end
        MUL_DONE: begin
          if (i_rdy) begin
            o_val <= 1'b0;
            state <= MUL_IDLE;
          end
        end
        default: state <= MUL_IDLE;
      endcase
    end
  end

  // reduced operands keep the accumulator bound
  a_ops_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_op.op_val && i_op.op_rdy) |-> (i_op.op_a < i_p && i_op.op_b < i_p));

endmodule

`default_nettype wire

// File: design/x_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module x_fifo #(
  parameter int BITS       = ec_conv_pkg::DEF_BITS,
  parameter int FIFO_DEPTH = ec_conv_pkg::DEF_FIFO_DEPTH
) (
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire [BITS-1:0]   i_dat,
  input  wire              i_push,
  output logic             o_full,
  output logic [BITS-1:0]  o_dat,   // head, fall-through
  input  wire              i_pop,
  output logic             o_empty
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [BITS-1:0]  mem [FIFO_DEPTH]; // storage
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;            // occupancy

  always_ff @(posedge i_clk) begin
    if (i_push) mem[wr_ptr] <= i_dat;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (i_pop)  rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // idle or push and pop together
      endcase
    end
  end

  assign o_dat   = mem[rd_ptr];
  assign o_full  = (count == CNT_W'(FIFO_DEPTH));
  assign o_empty = (count == '0);

  a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_push && o_full));

  a_no_underflow: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_pop && o_empty));

endmodule

`default_nettype wire

// File: design/affine_conv.sv
`timescale 1ns/1ps
`default_nettype none

// (X, Z) -> X * Z^-1 mod p
module affine_conv #(
  parameter int BITS       = ec_conv_pkg::DEF_BITS,
  parameter int FIFO_DEPTH = ec_conv_pkg::DEF_FIFO_DEPTH
) (
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire [BITS-1:0]   i_p,    // odd prime, fixed while busy
  input  wire [BITS-1:0]   i_x,
  input  wire [BITS-1:0]   i_z,    // nonzero
  input  wire              i_val,
  output logic             o_rdy,
  output logic [BITS-1:0]  o_dat,
  output logic             o_val,
  input  wire              i_rdy
);

  logic            inv_rdy, inv_val;
  logic [BITS-1:0] inv_dat;
  logic            fifo_full, fifo_empty, fifo_pop;
  logic [BITS-1:0] fifo_dat;
  logic            accept; // pair taken this cycle

  mul_op_if #(.BITS(BITS)) u_mul_op ();

  // ########################################
  // split, Z to the inverter and X to the fifo
  // ########################################

  assign o_rdy  = inv_rdy && !fifo_full;
  assign accept = i_val && o_rdy;

  bin_inv #(.BITS(BITS)) u_bin_inv (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_dat (i_z),
    .i_val (accept),
    .i_p   (i_p),
    .o_rdy (inv_rdy),
    .o_dat (inv_dat),
    .o_val (inv_val),
    .i_rdy (u_mul_op.op_rdy && !fifo_empty)
  );

  x_fifo #(.BITS(BITS), .FIFO_DEPTH(FIFO_DEPTH)) u_x_fifo (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_dat   (i_x),
    .i_push  (accept),
    .o_full  (fifo_full),
    .o_dat   (fifo_dat),
    .i_pop   (fifo_pop),
    .o_empty (fifo_empty)
  );

  // ########################################
  // join, inverse with the X at the fifo head
  // ########################################

  assign u_mul_op.op_a   = inv_dat;
  assign u_mul_op.op_b   = fifo_dat;
  assign u_mul_op.op_val = inv_val && !fifo_empty;
  assign fifo_pop        = u_mul_op.op_val && u_mul_op.op_rdy; // same transfer acks inverter

  mod_mult #(.BITS(BITS)) u_mod_mult (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_op  (u_mul_op.sink),
    .i_p   (i_p),
    .o_dat (o_dat),
    .o_val (o_val),
    .i_rdy (i_rdy)
  );

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD     = 8.0,
  parameter int  RST_CYCLES = 2
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2.0) o_clk = ~o_clk;
  end

  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1;
    o_rst = 1'b0; // released off the edge like other stimulus
  end

endmodule

`default_nettype wire

// File: test/tb_affine_conv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_affine_conv;

  localparam int BITS        = 16;
  localparam int TOTAL_PAIRS = 470;                 // 8 + 12 + 200 + 200 + 50
  localparam int CYCLE_LIMIT = TOTAL_PAIRS * (5 * BITS + 20) + 2000;

  logic            clk, rst;
  logic [BITS-1:0] i_p, i_x, i_z;
  logic            i_val, i_rdy;
  logic            o_rdy, o_val;
  logic [BITS-1:0] o_dat;

  integer          seed = 32'hd978;
  int              cycle_cnt = 0;
  int              err_cnt   = 0;  // whole run
  int              test_err  = 0;  // current test only
  int              tests_run = 0;
  int              tests_bad = 0;
  int              max_inflight;   // peak of accepted minus returned
  longint          p_cur;          // modulus the model works with
  logic [BITS-1:0] x_q[$], z_q[$], exp_q[$];

  tb_clk_gen #(.PERIOD(8.0), .RST_CYCLES(2)) u_clk_gen (.o_clk(clk), .o_rst(rst));

  affine_conv #(.BITS(BITS)) u_affine_conv (
    .i_clk (clk),
    .i_rst (rst),
    .i_p   (i_p),
    .i_x   (i_x),
    .i_z   (i_z),
    .i_val (i_val),
    .o_rdy (o_rdy),
    .o_dat (o_dat),
    .o_val (o_val),
    .i_rdy (i_rdy)
  );

  // ########################################
  // reference model
  // ########################################

  // extended euclid for a nonzero and below m
  function automatic longint inv_mod(input longint a, input longint m);
    longint t, new_t, r, new_r, q, tmp;
    t     = 0;
    new_t = 1;
    r     = m;
    new_r = a;
    while (new_r != 0) begin
      q     = r / new_r;
      tmp   = t - q * new_t;
      t     = new_t;
      new_t = tmp;
      tmp   = r - q * new_r;
      r     = new_r;
      new_r = tmp;
    end
    if (t < 0) t = t + m;
    return t;
  endfunction

  function automatic logic [BITS-1:0] expect_of(input logic [BITS-1:0] x, z);
    return BITS'((longint'(x) * inv_mod(longint'(z), p_cur)) % p_cur);
  endfunction

  function automatic logic [BITS-1:0] rand_res();
    return BITS'($unsigned($random(seed)) % p_cur); // any residue
  endfunction

  function automatic logic [BITS-1:0] rand_nonzero();
    return BITS'(1 + $unsigned($random(seed)) % (p_cur - 1));
  endfunction

  // ########################################
  // helpers
  // ########################################

  task automatic value_error(input string msg, input logic [BITS-1:0] expv, got);
    $display("** Error: [%0t] %s: expected %0d, got %0d", $time, msg, expv, got);
    err_cnt++;
    test_err++;
  endtask

  task automatic flag_failure(input string msg);
    $display("[%0t] %s", $time, msg); // non-value problem in plain words
    err_cnt++;
    test_err++;
  endtask

  task automatic add_pair(input logic [BITS-1:0] x, z, expv);
    x_q.push_back(x);
    z_q.push_back(z);
    exp_q.push_back(expv);
  endtask

  task automatic close_test(input string name);
    tests_run++;
    if (test_err != 0) tests_bad++;
    $display("test %-10s %s, %0d errors", name, (test_err == 0) ? "ok" : "BAD", test_err);
    test_err = 0;
  endtask

  task automatic set_modulus(input longint p);
    @(posedge clk);
    #1;
    i_p   = BITS'(p); // only while drained
    p_cur = p;
  endtask

  // sample at negedge, drive 1 ns after posedge
  task automatic run_stream(input bit rand_val, input bit rand_rdy);
    int              n_total, n_in, n_out;
    bit              take_in, take_out, stall;
    logic [BITS-1:0] held, expv;
    n_total      = exp_q.size();
    n_in         = 0;
    n_out        = 0;
    stall        = 1'b0;
    held         = '0;
    max_inflight = 0;
    while (n_out < n_total) begin
      @(negedge clk);
      if (stall && (o_val !== 1'b1 || o_dat !== held))
        value_error("output moved while stalled", held, o_dat);
      take_in  = i_val && o_rdy;
      take_out = o_val && i_rdy;
      stall    = o_val && !i_rdy;
      held     = o_dat;
      if (take_in) begin
        void'(x_q.pop_front());
        void'(z_q.pop_front());
        n_in++;
      end
      if (take_out) begin
        expv = exp_q.pop_front();
        if (o_dat !== expv) value_error("result mismatch", expv, o_dat);
        n_out++;
      end
      if (n_in - n_out > max_inflight) max_inflight = n_in - n_out;
      @(posedge clk);
      #1;
      i_val = (x_q.size() != 0) && (!rand_val || ($random(seed) & 1) != 0);
      if (i_val) begin
        i_x = x_q[0];
        i_z = z_q[0];
      end
      i_rdy = !rand_rdy || ($random(seed) & 1) != 0;
    end
    i_val = 1'b0;
    i_rdy = 1'b0;
    @(negedge clk);
    if (o_val !== 1'b0) flag_failure("extra result after the last expected one");
  endtask

  // ########################################
  // tests
  // ########################################

  initial begin
    logic [BITS-1:0] x;
    logic [BITS-1:0] z;
    i_p   = 16'd65521;
    p_cur = 65521;
    i_x   = '0;
    i_z   = '0;
    i_val = 1'b0;
    i_rdy = 1'b0;

    // outputs low in reset and o_rdy up one edge after release
    @(negedge clk);
    if (o_val !== 1'b0 || o_rdy !== 1'b0) flag_failure("outputs not low during reset");
    @(negedge rst);
    @(negedge clk);
    if (o_val !== 1'b0) flag_failure("o_val high right after reset");
    @(negedge clk);
    if (o_rdy !== 1'b1) flag_failure("o_rdy did not rise on the first cycle after reset");
    if (o_val !== 1'b0) flag_failure("o_val high with nothing accepted");
    close_test("reset");

    set_modulus(65521);
    for (int k = 0; k < 8; k++) begin
      x = rand_res();
      add_pair(x, 1, x); // inverse of one is one
    end
    run_stream(1'b0, 1'b0);
    close_test("z_one");

    for (int k = 0; k < 4; k++) add_pair('0, rand_nonzero(), '0);
    for (int k = 0; k < 4; k++) begin
      x = rand_res();
      add_pair(x, BITS'(p_cur - 1), BITS'((p_cur - x) % p_cur)); // -1 inverts to -1
    end
    for (int k = 0; k < 4; k++) begin
      x = rand_res();
      add_pair(x, 2, BITS'((longint'(x) * ((p_cur + 1) / 2)) % p_cur));
    end
    run_stream(1'b0, 1'b0);
    close_test("edges");

    for (int k = 0; k < 200; k++) begin
      x = rand_res();
      z = rand_nonzero();
      add_pair(x, z, expect_of(x, z));
    end
    run_stream(1'b0, 1'b0);
    if (max_inflight < 2) flag_failure("no pair accepted while a product was in flight");
    close_test("stream");

    set_modulus(32749);
    for (int k = 0; k < 200; k++) begin
      x = rand_res();
      z = rand_nonzero();
      add_pair(x, z, expect_of(x, z));
    end
    run_stream(1'b1, 1'b1); // random valid and ready
    close_test("random_hs");

    set_modulus(251);
    for (int b = 0; b < 2; b++) begin
      for (int k = 0; k < 25; k++) begin
        x = rand_res();
        z = rand_nonzero();
        add_pair(x, z, expect_of(x, z));
      end
      run_stream(1'b0, 1'b0);
      repeat (10) @(posedge clk); // idle gap with the pipeline drained
    end
    close_test("small_p");

    $display("%0d tests, %0d bad, %0d errors", tests_run, tests_bad, err_cnt);
    if (err_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: files.f
design/ec_conv_pkg.sv
design/mul_op_if.sv
design/bin_inv.sv
design/mod_mult.sv
design/x_fifo.sv
design/affine_conv.sv
test/tb_clk_gen.sv
test/tb_affine_conv.sv
